// ==== hdl/soc_pkg.sv ====
package soc_pkg;

  // ##################################################
  // Bus widths.
  // ##################################################
  localparam int XLEN   = 32;
  localparam int STRB_W = 4;

  // ##################################################
  // Address map.
  // ##################################################
  localparam logic [XLEN-1:0] BRAM_BASE  = 32'h0000_0000;
  localparam logic [XLEN-1:0] BRAM_TOP   = 32'h0000_1000;
  localparam logic [XLEN-1:0] PRINT_BASE = 32'h1000_0000;
  localparam logic [XLEN-1:0] PRINT_TOP  = 32'h1000_0010;
  localparam logic [XLEN-1:0] CLINT_BASE = 32'h0200_0000;
  localparam logic [XLEN-1:0] CLINT_TOP  = 32'h0200_C000;

  // Words in the block RAM.
  localparam int BRAM_DEPTH = 1024;

  // ##################################################
  // CLINT register offsets.
  // ##################################################
  localparam logic [XLEN-1:0] MSIP_OFS        = 32'h0000_0000;
  localparam logic [XLEN-1:0] MTIMECMP_LO_OFS = 32'h0000_4000;
  localparam logic [XLEN-1:0] MTIMECMP_HI_OFS = 32'h0000_4004;
  localparam logic [XLEN-1:0] MTIME_LO_OFS    = 32'h0000_BFF8;
  localparam logic [XLEN-1:0] MTIME_HI_OFS    = 32'h0000_BFFC;

  localparam int MTIME_W = 64;

endpackage

// ==== hdl/bus_router.sv ====
`timescale 1ns/100ps

module bus_router
  import soc_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  // Instruction master.
  input  logic              imem_valid_i,
  input  logic [XLEN-1:0]   imem_addr_i,
  input  logic [XLEN-1:0]   imem_wdata_i,
  input  logic [STRB_W-1:0] imem_wstrb_i,
  output logic [XLEN-1:0]   imem_rdata_o,
  output logic              imem_ready_o,
  // Data master.
  input  logic              dmem_valid_i,
  input  logic [XLEN-1:0]   dmem_addr_i,
  input  logic [XLEN-1:0]   dmem_wdata_i,
  input  logic [STRB_W-1:0] dmem_wstrb_i,
  output logic [XLEN-1:0]   dmem_rdata_o,
  output logic              dmem_ready_o,
  // Block RAM slave.
  output logic              bram_valid_o,
  output logic [XLEN-1:0]   bram_addr_o,
  output logic [XLEN-1:0]   bram_wdata_o,
  output logic [STRB_W-1:0] bram_wstrb_o,
  input  logic [XLEN-1:0]   bram_rdata_i,
  input  logic              bram_ready_i,
  // Print slave.
  output logic              print_valid_o,
  output logic [XLEN-1:0]   print_addr_o,
  output logic [XLEN-1:0]   print_wdata_o,
  output logic [STRB_W-1:0] print_wstrb_o,
  input  logic [XLEN-1:0]   print_rdata_i,
  input  logic              print_ready_i,
  // CLINT slave.
  output logic              clint_valid_o,
  output logic [XLEN-1:0]   clint_addr_o,
  output logic [XLEN-1:0]   clint_wdata_o,
  output logic [STRB_W-1:0] clint_wstrb_o,
  input  logic [XLEN-1:0]   clint_rdata_i,
  input  logic              clint_ready_i
);

  // Slave vectors are ordered {clint, print, bram}.
  logic [2:0]      own_i_q;
  logic [2:0]      own_d_q;
  logic [2:0]      own_i_d;
  logic [2:0]      own_d_d;
  logic [2:0]      hit_i;
  logic [2:0]      hit_d;
  logic [2:0]      slv_ready;
  logic [2:0]      done_i;
  logic [2:0]      done_d;
  logic [XLEN-1:0] addr_i_rb;
  logic [XLEN-1:0] addr_d_rb;

  function automatic logic in_window(input logic [XLEN-1:0] addr,
                                     input logic [XLEN-1:0] base,
                                     input logic [XLEN-1:0] top);
    return (addr - base) < (top - base);
  endfunction

  // Clint first, then print; anything else lands on the RAM.
  function automatic logic [2:0] decode(input logic [XLEN-1:0] addr);
    if (in_window(addr, CLINT_BASE, CLINT_TOP)) begin
      return 3'b100;
    end else if (in_window(addr, PRINT_BASE, PRINT_TOP)) begin
      return 3'b010;
    end
    return 3'b001;
  endfunction

  function automatic logic [XLEN-1:0] rebase(input logic [XLEN-1:0] addr);
    if (in_window(addr, CLINT_BASE, CLINT_TOP)) begin
      return addr - CLINT_BASE;
    end else if (in_window(addr, PRINT_BASE, PRINT_TOP)) begin
      return addr - PRINT_BASE;
    end else if (in_window(addr, BRAM_BASE, BRAM_TOP)) begin
      return addr - BRAM_BASE;
    end
    return addr;
  endfunction

  assign hit_i     = decode(imem_addr_i);
  assign hit_d     = decode(dmem_addr_i);
  assign addr_i_rb = rebase(imem_addr_i);
  assign addr_d_rb = rebase(dmem_addr_i);

  // ##################################################
  // Responses follow the registered owner.
  // ##################################################
  assign slv_ready = {clint_ready_i, print_ready_i, bram_ready_i};
  assign done_i    = own_i_q & slv_ready;
  assign done_d    = own_d_q & slv_ready;

  assign imem_ready_o = |done_i;
  assign dmem_ready_o = |done_d;

  assign imem_rdata_o = ({XLEN{done_i[0]}} & bram_rdata_i)
                      | ({XLEN{done_i[1]}} & print_rdata_i)
                      | ({XLEN{done_i[2]}} & clint_rdata_i);
  assign dmem_rdata_o = ({XLEN{done_d[0]}} & bram_rdata_i)
                      | ({XLEN{done_d[1]}} & print_rdata_i)
                      | ({XLEN{done_d[2]}} & clint_rdata_i);

  // ##################################################
  // Grant.
  // ##################################################
  always_comb begin
    own_d_d = own_d_q & ~slv_ready;
    own_i_d = own_i_q & ~slv_ready;
    // A master is not decoded again in its own ready cycle.
    if (dmem_valid_i && !dmem_ready_o) begin
      own_d_d = own_d_d | hit_d;
    end
    if (imem_valid_i && !imem_ready_o) begin
      own_i_d = own_i_d | hit_i;
    end
    // Data wins a shared slave.
    own_i_d = own_i_d & ~own_d_d;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      own_i_q <= '0;
      own_d_q <= '0;
    end else begin
      own_i_q <= own_i_d;
      own_d_q <= own_d_d;
    end
  end

  // Slave side muxes.
  assign bram_valid_o  = (own_d_d[0] & dmem_valid_i) | (own_i_d[0] & imem_valid_i);
  assign bram_addr_o   = own_d_d[0] ? addr_d_rb : addr_i_rb;
  assign bram_wdata_o  = own_d_d[0] ? dmem_wdata_i : imem_wdata_i;
  assign bram_wstrb_o  = own_d_d[0] ? dmem_wstrb_i : imem_wstrb_i;

  assign print_valid_o = (own_d_d[1] & dmem_valid_i) | (own_i_d[1] & imem_valid_i);
  assign print_addr_o  = own_d_d[1] ? addr_d_rb : addr_i_rb;
  assign print_wdata_o = own_d_d[1] ? dmem_wdata_i : imem_wdata_i;
  assign print_wstrb_o = own_d_d[1] ? dmem_wstrb_i : imem_wstrb_i;

  assign clint_valid_o = (own_d_d[2] & dmem_valid_i) | (own_i_d[2] & imem_valid_i);
  assign clint_addr_o  = own_d_d[2] ? addr_d_rb : addr_i_rb;
  assign clint_wdata_o = own_d_d[2] ? dmem_wdata_i : imem_wdata_i;
  assign clint_wstrb_o = own_d_d[2] ? dmem_wstrb_i : imem_wstrb_i;

endmodule

// ==== hdl/bram.sv ====
`timescale 1ns/100ps

module bram
  import soc_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              valid_i,
  input  logic [XLEN-1:0]   addr_i,
  input  logic [XLEN-1:0]   wdata_i,
  input  logic [STRB_W-1:0] wstrb_i,
  output logic [XLEN-1:0]   rdata_o,
  output logic              ready_o
);

  logic [XLEN-1:0]               mem [BRAM_DEPTH];
  logic [$clog2(BRAM_DEPTH)-1:0] word_addr;
  logic                          accept;

  // Byte address to word index.
  assign word_addr = addr_i[$clog2(BRAM_DEPTH)+1:2];

  // Skip the cycle after ready so a held request runs once.
  assign accept = valid_i & ~ready_o;

  always_ff @(posedge clk) begin
    if (accept) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem[word_addr][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      rdata_o <= mem[word_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_o <= 1'b0;
    end else begin
      ready_o <= accept;
    end
  end

endmodule

// ==== hdl/clint.sv ====
`timescale 1ns/100ps

module clint
  import soc_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              rtc_i,
  input  logic              valid_i,
  input  logic [XLEN-1:0]   addr_i,
  input  logic [XLEN-1:0]   wdata_i,
  input  logic [STRB_W-1:0] wstrb_i,
  output logic [XLEN-1:0]   rdata_o,
  output logic              ready_o,
  output logic              msip_o,
  output logic              mtip_o
);

  logic [2:0]         rtc_sync;
  logic               rtc_rise;
  logic [MTIME_W-1:0] mtime_q;
  logic [MTIME_W-1:0] mtimecmp_q;
  logic               msip_q;
  logic               accept;
  logic               wr_en;
  logic [XLEN-1:0]    rd_data;

  function automatic logic [XLEN-1:0] merge(input logic [XLEN-1:0]   old,
                                            input logic [XLEN-1:0]   data,
                                            input logic [STRB_W-1:0] strb);
    logic [XLEN-1:0] res;
    res = old;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  // ##################################################
  // RTC synchronizer and edge detect.
  // ##################################################
  always_ff @(posedge clk) begin
    if (!rst) begin
      rtc_sync <= '0;
    end else begin
      rtc_sync <= {rtc_sync[1:0], rtc_i};
    end
  end

  assign rtc_rise = rtc_sync[1] & ~rtc_sync[2];

  assign accept = valid_i & ~ready_o;
  assign wr_en  = accept & (|wstrb_i);

  // ##################################################
  // Registers.
  // ##################################################
  always_ff @(posedge clk) begin
    if (!rst) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      mtip_o     <= 1'b0;
      ready_o    <= 1'b0;
    end else begin
      ready_o <= accept;
      mtip_o  <= mtime_q >= mtimecmp_q;
      if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
      // A software write beats the tick.
      if (wr_en) begin
        case (addr_i)
          MSIP_OFS: begin
            if (wstrb_i[0]) begin
              msip_q <= wdata_i[0];
            end
          end
          MTIMECMP_LO_OFS: mtimecmp_q[XLEN-1:0] <= merge(mtimecmp_q[XLEN-1:0], wdata_i, wstrb_i);
          MTIMECMP_HI_OFS: begin
            mtimecmp_q[MTIME_W-1:XLEN] <= merge(mtimecmp_q[MTIME_W-1:XLEN], wdata_i, wstrb_i);
          end
          MTIME_LO_OFS: mtime_q[XLEN-1:0] <= merge(mtime_q[XLEN-1:0], wdata_i, wstrb_i);
          MTIME_HI_OFS: mtime_q[MTIME_W-1:XLEN] <= merge(mtime_q[MTIME_W-1:XLEN], wdata_i, wstrb_i);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (addr_i)
      MSIP_OFS:        rd_data = {{(XLEN-1){1'b0}}, msip_q};
      MTIMECMP_LO_OFS: rd_data = mtimecmp_q[XLEN-1:0];
      MTIMECMP_HI_OFS: rd_data = mtimecmp_q[MTIME_W-1:XLEN];
      MTIME_LO_OFS:    rd_data = mtime_q[XLEN-1:0];
      MTIME_HI_OFS:    rd_data = mtime_q[MTIME_W-1:XLEN];
      default:         rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rdata_o <= rd_data;
    end
  end

  assign msip_o = msip_q;

endmodule

// ==== hdl/print.sv ====
`timescale 1ns/100ps

module print
  import soc_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              valid_i,
  input  logic [XLEN-1:0]   addr_i,
  input  logic [XLEN-1:0]   wdata_i,
  input  logic [STRB_W-1:0] wstrb_i,
  output logic [XLEN-1:0]   rdata_o,
  output logic              ready_o,
  output logic [7:0]        char_o,
  output logic              char_valid_o
);

  logic accept;
  logic emit;

  assign accept = valid_i & ~ready_o;
  // Only the low byte lane carries a character.
  assign emit   = accept & wstrb_i[0] & (addr_i < (PRINT_TOP - PRINT_BASE));

  assign rdata_o = '0;

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_o      <= 1'b0;
      char_valid_o <= 1'b0;
    end else begin
      ready_o      <= accept;
      char_valid_o <= emit;
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      char_o <= wdata_i[7:0];
    end
  end

endmodule

// ==== hdl/soc_top.sv ====
`timescale 1ns/100ps

module soc_top
  import soc_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              rtc_i,
  input  logic              imem_valid_i,
  input  logic [XLEN-1:0]   imem_addr_i,
  input  logic [XLEN-1:0]   imem_wdata_i,
  input  logic [STRB_W-1:0] imem_wstrb_i,
  output logic [XLEN-1:0]   imem_rdata_o,
  output logic              imem_ready_o,
  input  logic              dmem_valid_i,
  input  logic [XLEN-1:0]   dmem_addr_i,
  input  logic [XLEN-1:0]   dmem_wdata_i,
  input  logic [STRB_W-1:0] dmem_wstrb_i,
  output logic [XLEN-1:0]   dmem_rdata_o,
  output logic              dmem_ready_o,
  output logic [7:0]        char_o,
  output logic              char_valid_o,
  output logic              msip_o,
  output logic              mtip_o
);

  logic              bram_valid;
  logic [XLEN-1:0]   bram_addr;
  logic [XLEN-1:0]   bram_wdata;
  logic [STRB_W-1:0] bram_wstrb;
  logic [XLEN-1:0]   bram_rdata;
  logic              bram_ready;

  logic              print_valid;
  logic [XLEN-1:0]   print_addr;
  logic [XLEN-1:0]   print_wdata;
  logic [STRB_W-1:0] print_wstrb;
  logic [XLEN-1:0]   print_rdata;
  logic              print_ready;

  logic              clint_valid;
  logic [XLEN-1:0]   clint_addr;
  logic [XLEN-1:0]   clint_wdata;
  logic [STRB_W-1:0] clint_wstrb;
  logic [XLEN-1:0]   clint_rdata;
  logic              clint_ready;

  bus_router u_router (
    .clk           (clk),
    .rst           (rst),
    .imem_valid_i  (imem_valid_i),
    .imem_addr_i   (imem_addr_i),
    .imem_wdata_i  (imem_wdata_i),
    .imem_wstrb_i  (imem_wstrb_i),
    .imem_rdata_o  (imem_rdata_o),
    .imem_ready_o  (imem_ready_o),
    .dmem_valid_i  (dmem_valid_i),
    .dmem_addr_i   (dmem_addr_i),
    .dmem_wdata_i  (dmem_wdata_i),
    .dmem_wstrb_i  (dmem_wstrb_i),
    .dmem_rdata_o  (dmem_rdata_o),
    .dmem_ready_o  (dmem_ready_o),
    .bram_valid_o  (bram_valid),
    .bram_addr_o   (bram_addr),
    .bram_wdata_o  (bram_wdata),
    .bram_wstrb_o  (bram_wstrb),
    .bram_rdata_i  (bram_rdata),
    .bram_ready_i  (bram_ready),
    .print_valid_o (print_valid),
    .print_addr_o  (print_addr),
    .print_wdata_o (print_wdata),
    .print_wstrb_o (print_wstrb),
    .print_rdata_i (print_rdata),
    .print_ready_i (print_ready),
    .clint_valid_o (clint_valid),
    .clint_addr_o  (clint_addr),
    .clint_wdata_o (clint_wdata),
    .clint_wstrb_o (clint_wstrb),
    .clint_rdata_i (clint_rdata),
    .clint_ready_i (clint_ready)
  );

  bram u_bram (
    .clk     (clk),
    .rst     (rst),
    .valid_i (bram_valid),
    .addr_i  (bram_addr),
    .wdata_i (bram_wdata),
    .wstrb_i (bram_wstrb),
    .rdata_o (bram_rdata),
    .ready_o (bram_ready)
  );

  print u_print (
    .clk          (clk),
    .rst          (rst),
    .valid_i      (print_valid),
    .addr_i       (print_addr),
    .wdata_i      (print_wdata),
    .wstrb_i      (print_wstrb),
    .rdata_o      (print_rdata),
    .ready_o      (print_ready),
    .char_o       (char_o),
    .char_valid_o (char_valid_o)
  );

  clint u_clint (
    .clk     (clk),
    .rst     (rst),
    .rtc_i   (rtc_i),
    .valid_i (clint_valid),
    .addr_i  (clint_addr),
    .wdata_i (clint_wdata),
    .wstrb_i (clint_wstrb),
    .rdata_o (clint_rdata),
    .ready_o (clint_ready),
    .msip_o  (msip_o),
    .mtip_o  (mtip_o)
  );

endmodule

// ==== test/soc_sva.sv ====
`timescale 1ns/100ps

module soc_sva
  import soc_pkg::*;
#(
  parameter bit CHECK_BUS   = 1'b1,
  parameter bit CHECK_TIMER = 1'b1
) (
  input logic               clk,
  input logic               rst,
  input logic [2:0]         slv_valid,
  input logic [2:0]         slv_ready,
  input logic [1:0]         mst_ready,
  input logic               mtip,
  input logic [MTIME_W-1:0] mtime,
  input logic [MTIME_W-1:0] mtimecmp
);

  generate
    if (CHECK_BUS) begin : g_bus
      // Ready only answers a request seen the cycle before.
      slave_ready_after_valid: assert property (
        @(posedge clk) disable iff (!rst) (slv_ready & ~$past(slv_valid)) == 3'b000
      ) else $error("slave ready without a request in the previous cycle");

      master_ready_single: assert property (
        @(posedge clk) disable iff (!rst) (mst_ready & $past(mst_ready)) == 2'b00
      ) else $error("master ready held for two cycles");
    end

    if (CHECK_TIMER) begin : g_timer
      timer_compare: assert property (
        @(posedge clk) disable iff (!rst) mtip == $past(mtime >= mtimecmp)
      ) else $error("mtip does not follow the timer comparison");
    end
  endgenerate

endmodule

// ##################################################
// Router side and CLINT side.
// ##################################################
bind bus_router soc_sva #(.CHECK_BUS(1'b1), .CHECK_TIMER(1'b0)) u_router_sva (
  .clk       (clk),
  .rst       (rst),
  .slv_valid ({clint_valid_o, print_valid_o, bram_valid_o}),
  .slv_ready ({clint_ready_i, print_ready_i, bram_ready_i}),
  .mst_ready ({imem_ready_o, dmem_ready_o}),
  .mtip      (1'b0),
  .mtime     (64'd0),
  .mtimecmp  (64'd0)
);

bind clint soc_sva #(.CHECK_BUS(1'b0), .CHECK_TIMER(1'b1)) u_clint_sva (
  .clk       (clk),
  .rst       (rst),
  .slv_valid (3'b000),
  .slv_ready (3'b000),
  .mst_ready (2'b00),
  .mtip      (mtip_o),
  .mtime     (mtime_q),
  .mtimecmp  (mtimecmp_q)
);

// ==== test/soc_tb.sv ====
`timescale 1ns/100ps

module soc_tb
  import soc_pkg::*;
;

  localparam int MAX_CYCLES = 4000;
  localparam int N_WORDS    = 16;

  logic              clk;
  logic              rst;
  logic              rtc_i;
  logic              imem_valid_i;
  logic [XLEN-1:0]   imem_addr_i;
  logic [XLEN-1:0]   imem_wdata_i;
  logic [STRB_W-1:0] imem_wstrb_i;
  logic [XLEN-1:0]   imem_rdata_o;
  logic              imem_ready_o;
  logic              dmem_valid_i;
  logic [XLEN-1:0]   dmem_addr_i;
  logic [XLEN-1:0]   dmem_wdata_i;
  logic [STRB_W-1:0] dmem_wstrb_i;
  logic [XLEN-1:0]   dmem_rdata_o;
  logic              dmem_ready_o;
  logic [7:0]        char_o;
  logic              char_valid_o;
  logic              msip_o;
  logic              mtip_o;

  // Reference state.
  logic [XLEN-1:0]    shadow_mem [BRAM_DEPTH];
  logic [MTIME_W-1:0] shadow_cmp;
  logic               shadow_msip;
  logic [MTIME_W-1:0] rtc_cnt;

  logic [XLEN-1:0] d_exp_q[$];
  logic            d_chk_q[$];
  logic [XLEN-1:0] i_exp_q[$];
  logic            i_chk_q[$];
  logic [7:0]      char_q[$];

  int seed;
  int err_cnt;
  int err_mark;
  int pass_cnt;
  int fail_cnt;
  int cycles;

  soc_top uut (
    .clk          (clk),
    .rst          (rst),
    .rtc_i        (rtc_i),
    .imem_valid_i (imem_valid_i),
    .imem_addr_i  (imem_addr_i),
    .imem_wdata_i (imem_wdata_i),
    .imem_wstrb_i (imem_wstrb_i),
    .imem_rdata_o (imem_rdata_o),
    .imem_ready_o (imem_ready_o),
    .dmem_valid_i (dmem_valid_i),
    .dmem_addr_i  (dmem_addr_i),
    .dmem_wdata_i (dmem_wdata_i),
    .dmem_wstrb_i (dmem_wstrb_i),
    .dmem_rdata_o (dmem_rdata_o),
    .dmem_ready_o (dmem_ready_o),
    .char_o       (char_o),
    .char_valid_o (char_valid_o),
    .msip_o       (msip_o),
    .mtip_o       (mtip_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ##################################################
  // Reference model.
  // ##################################################
  function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0]   old,
                                                  input logic [XLEN-1:0]   data,
                                                  input logic [STRB_W-1:0] strb);
    logic [XLEN-1:0] res;
    res = old;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [XLEN-1:0] ref_read(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] ofs;
    ofs = addr - CLINT_BASE;
    if (addr >= CLINT_BASE && addr < CLINT_TOP) begin
      case (ofs)
        MSIP_OFS:        return {{(XLEN-1){1'b0}}, shadow_msip};
        MTIMECMP_LO_OFS: return shadow_cmp[XLEN-1:0];
        MTIMECMP_HI_OFS: return shadow_cmp[MTIME_W-1:XLEN];
        MTIME_LO_OFS:    return rtc_cnt[XLEN-1:0];
        MTIME_HI_OFS:    return rtc_cnt[MTIME_W-1:XLEN];
        default:         return '0;
      endcase
    end else if (addr >= PRINT_BASE && addr < PRINT_TOP) begin
      return '0;
    end
    // Everything else lands on the RAM by its low bits.
    return shadow_mem[addr[11:2]];
  endfunction

  task automatic update_shadow(input logic [XLEN-1:0]   addr,
                               input logic [XLEN-1:0]   data,
                               input logic [STRB_W-1:0] strb);
    logic [XLEN-1:0] ofs;
    ofs = addr - CLINT_BASE;
    if (addr >= CLINT_BASE && addr < CLINT_TOP) begin
      case (ofs)
        MSIP_OFS: if (strb[0]) shadow_msip = data[0];
        MTIMECMP_LO_OFS: begin
          shadow_cmp[XLEN-1:0] = merge_bytes(shadow_cmp[XLEN-1:0], data, strb);
        end
        MTIMECMP_HI_OFS: begin
          shadow_cmp[MTIME_W-1:XLEN] = merge_bytes(shadow_cmp[MTIME_W-1:XLEN], data, strb);
        end
        default: ;
      endcase
    end else if (addr >= PRINT_BASE && addr < PRINT_TOP) begin
      if (strb[0]) char_q.push_back(data[7:0]);
    end else begin
      shadow_mem[addr[11:2]] = merge_bytes(shadow_mem[addr[11:2]], data, strb);
    end
  endtask

  // ##################################################
  // Master ports.
  // ##################################################
  task automatic dmem_access(input logic [XLEN-1:0]   addr,
                             input logic [XLEN-1:0]   wdata,
                             input logic [STRB_W-1:0] strb);
    d_chk_q.push_back(strb == '0);
    d_exp_q.push_back(ref_read(addr));
    if (strb != '0) update_shadow(addr, wdata, strb);
    @(posedge clk);
    dmem_valid_i <= 1'b1;
    dmem_addr_i  <= addr;
    dmem_wdata_i <= wdata;
    dmem_wstrb_i <= strb;
    do @(negedge clk); while (!dmem_ready_o);
    @(posedge clk);
    dmem_valid_i <= 1'b0;
  endtask

  task automatic imem_access(input logic [XLEN-1:0]   addr,
                             input logic [XLEN-1:0]   wdata,
                             input logic [STRB_W-1:0] strb);
    i_chk_q.push_back(strb == '0);
    i_exp_q.push_back(ref_read(addr));
    if (strb != '0) update_shadow(addr, wdata, strb);
    @(posedge clk);
    imem_valid_i <= 1'b1;
    imem_addr_i  <= addr;
    imem_wdata_i <= wdata;
    imem_wstrb_i <= strb;
    do @(negedge clk); while (!imem_ready_o);
    @(posedge clk);
    imem_valid_i <= 1'b0;
  endtask

  task automatic rtc_pulse(input int gap);
    @(posedge clk);
    rtc_i <= 1'b1;
    repeat (2) @(posedge clk);
    rtc_i <= 1'b0;
    repeat (gap) @(posedge clk);
    rtc_cnt = rtc_cnt + 64'd1;
  endtask

  task automatic expect_irq(input logic exp_mtip, input logic exp_msip, input string step);
    repeat (3) @(posedge clk);
    @(negedge clk);
    assert (mtip_o === exp_mtip) else begin
      $display("Fail at %0d ns: mtip_o is %b, expected %b after %s",
               $time, mtip_o, exp_mtip, step);
      err_cnt++;
    end
    assert (msip_o === exp_msip) else begin
      $display("Fail at %0d ns: msip_o is %b, expected %b after %s",
               $time, msip_o, exp_msip, step);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    if (err_cnt == err_mark) begin
      pass_cnt++;
      $display("Test %s passed", name);
    end else begin
      fail_cnt++;
      $display("Test %s failed with %0d errors", name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  // ##################################################
  // Response checking.
  // ##################################################
  always @(negedge clk) begin
    if (dmem_ready_o) begin
      if (d_exp_q.size() == 0) begin
        $display("Data port gave a response that no request asked for");
        err_cnt++;
      end else begin
        if (d_chk_q.pop_front()) begin
          assert (dmem_rdata_o === d_exp_q[0]) else begin
            $display("Fail at %0d ns: dmem read %h, expected %h",
                     $time, dmem_rdata_o, d_exp_q[0]);
            err_cnt++;
          end
        end
        void'(d_exp_q.pop_front());
      end
    end
    if (imem_ready_o) begin
      if (i_exp_q.size() == 0) begin
        $display("Instruction port gave a response that no request asked for");
        err_cnt++;
      end else begin
        if (i_chk_q.pop_front()) begin
          assert (imem_rdata_o === i_exp_q[0]) else begin
            $display("Fail at %0d ns: imem read %h, expected %h",
                     $time, imem_rdata_o, i_exp_q[0]);
            err_cnt++;
          end
        end
        void'(i_exp_q.pop_front());
      end
    end
    if (char_valid_o) begin
      if (char_q.size() == 0) begin
        $display("Print port emitted a character that was not written");
        err_cnt++;
      end else begin
        assert (char_o === char_q[0]) else begin
          $display("Fail at %0d ns: char %h, expected %h", $time, char_o, char_q[0]);
          err_cnt++;
        end
        void'(char_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ##################################################
  // Stimulus.
  // ##################################################
  initial begin
    logic [9:0]      words [N_WORDS];
    logic [XLEN-1:0] tmp;
    logic [XLEN-1:0] addr;
    time             t_d;
    time             t_i;
    int              n;

    seed         = 95929;
    err_cnt      = 0;
    err_mark     = 0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    cycles       = 0;
    shadow_cmp   = '1;
    shadow_msip  = 1'b0;
    rtc_cnt      = '0;
    rst          = 1'b0;
    rtc_i        = 1'b0;
    imem_valid_i = 1'b0;
    imem_addr_i  = '0;
    imem_wdata_i = '0;
    imem_wstrb_i = '0;
    dmem_valid_i = 1'b0;
    dmem_addr_i  = '0;
    dmem_wdata_i = '0;
    dmem_wstrb_i = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b1;

    // Full words first, so no byte stays unknown.
    for (int k = 0; k < N_WORDS; k++) begin
      tmp      = $random(seed);
      words[k] = 10'(k * 64) | {4'd0, tmp[5:0]};
      addr     = BRAM_BASE + {20'd0, words[k], 2'b00};
      dmem_access(addr, $random(seed), 4'hF);
      tmp = $random(seed);
      if (tmp[3:0] == 4'h0) tmp[3:0] = 4'h5;
      dmem_access(addr, $random(seed), tmp[3:0]);
    end
    for (int k = 0; k < N_WORDS; k++) begin
      addr = BRAM_BASE + {20'd0, words[k], 2'b00};
      dmem_access(addr, '0, '0);
      imem_access(addr, '0, '0);
    end
    end_test("ram_strobes");

    for (int k = 0; k < 4; k++) begin
      fork
        begin
          dmem_access({20'd0, words[k], 2'b00}, '0, '0);
          t_d = $time;
        end
        begin
          imem_access({20'd0, words[k+4], 2'b00}, '0, '0);
          t_i = $time;
        end
      join
      assert (t_d < t_i) else begin
        $display("Fail at %0d ns: instruction port finished before data port", $time);
        err_cnt++;
      end
    end
    end_test("same_slave_conflict");

    fork
      imem_access({20'd0, words[9], 2'b00}, '0, '0);
      dmem_access(CLINT_BASE + MTIMECMP_LO_OFS, $random(seed), 4'hF);
    join
    dmem_access(CLINT_BASE + MTIMECMP_LO_OFS, '0, '0);
    end_test("parallel_masters");

    for (int k = 0; k < 6; k++) begin
      tmp = $random(seed);
      dmem_access(PRINT_BASE, tmp, 4'h1);
      dmem_access(PRINT_BASE + 32'h4, tmp, 4'b1110);
    end
    dmem_access(PRINT_BASE, '0, '0);
    repeat (2) @(posedge clk);
    assert (char_q.size() == 0) else begin
      $display("Print port lost %0d characters", char_q.size());
      err_cnt++;
    end
    end_test("print_port");

    tmp = $random(seed);
    n   = 3 + int'(tmp[2:0]);
    for (int k = 0; k < n; k++) begin
      tmp = $random(seed);
      rtc_pulse(5 + int'(tmp[1:0]));
    end
    dmem_access(CLINT_BASE + MTIME_LO_OFS, '0, '0);
    dmem_access(CLINT_BASE + MTIME_HI_OFS, '0, '0);
    dmem_access(CLINT_BASE + MTIMECMP_LO_OFS, '0, 4'hF);
    dmem_access(CLINT_BASE + MTIMECMP_HI_OFS, '0, 4'hF);
    expect_irq(1'b1, 1'b0, "mtimecmp below mtime");
    dmem_access(CLINT_BASE + MTIMECMP_HI_OFS, 32'h1, 4'hF);
    dmem_access(CLINT_BASE + MTIMECMP_HI_OFS, '0, '0);
    expect_irq(1'b0, 1'b0, "mtimecmp above mtime");
    dmem_access(CLINT_BASE + MSIP_OFS, 32'h1, 4'hF);
    expect_irq(1'b0, 1'b1, "msip set");
    dmem_access(CLINT_BASE + MSIP_OFS, '0, '0);
    dmem_access(CLINT_BASE + MSIP_OFS, 32'h0, 4'hF);
    expect_irq(1'b0, 1'b0, "msip clear");
    end_test("timer_interrupts");

    addr = 32'h3000_0000 | {20'd0, words[12], 2'b00};
    dmem_access(addr, $random(seed), 4'hF);
    dmem_access(addr, '0, '0);
    imem_access({20'd0, words[12], 2'b00}, '0, '0);
    end_test("unmapped_wrap");

    repeat (2) @(posedge clk);
    $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
hdl/soc_pkg.sv
hdl/bus_router.sv
hdl/bram.sv
hdl/clint.sv
hdl/print.sv
hdl/soc_top.sv
test/soc_sva.sv
test/soc_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module soc_tb -f tb.f -o soc_sim \
  || { echo "Build failed"; exit 1; }

./obj_dir/soc_sim | tee /dev/stderr | grep -q "^STATUS: PASS$" \
  && exit 0 \
  || exit 1
